/* logic/dacfifo_defines.svh */
`ifndef DACFIFO_DEFINES_SVH
`define DACFIFO_DEFINES_SVH

// data path widths
`define DMA_DATA_WIDTH 64
`define AVL_DATA_WIDTH 256
`define MEM_RATIO 4
`define RATIO_BITS 2

// buffer geometry, 64 narrow words or 16 wide words
`define DMA_ADDR_WIDTH 6
`define AVL_MEM_ADDR_WIDTH 4
`define FILL_THRESHOLD 60

// external memory window in avalon word addresses
`define AVL_ADDR_WIDTH 25
`define AVL_BE_WIDTH 32
`define AVL_BASE_ADDRESS 16
`define AVL_ADDRESS_LIMIT 31

`endif

/* logic/dacfifo_pkg.sv */
`include "dacfifo_defines.svh"

package dacfifo_pkg;

  // writer FSM states
  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    LOAD,
    WRITE,
    DONE
  } writer_state_t;

  // lane index of the final dma word inside its wide word
  typedef logic [`RATIO_BITS-1:0] last_beat_t;

endpackage

/* logic/dacfifo_asym_mem.sv */
`include "dacfifo_defines.svh"

module dacfifo_asym_mem (
  input  logic                            avl_clk,
  input  logic                            wr_en,
  input  logic [`DMA_ADDR_WIDTH-1:0]      wr_addr,
  input  logic [`DMA_DATA_WIDTH-1:0]      wr_data,
  input  logic [`AVL_MEM_ADDR_WIDTH-1:0]  rd_addr,
  output logic [`AVL_DATA_WIDTH-1:0]      rd_data
);

  localparam int DEPTH = 2 ** `AVL_MEM_ADDR_WIDTH;

  logic [`AVL_DATA_WIDTH-1:0]     mem [DEPTH];
  logic [`AVL_MEM_ADDR_WIDTH-1:0] wr_row;
  logic [`RATIO_BITS-1:0]         wr_lane;

  // upper address bits pick the wide row, low bits the narrow lane
  assign wr_row  = wr_addr[`DMA_ADDR_WIDTH-1:`RATIO_BITS];
  assign wr_lane = wr_addr[`RATIO_BITS-1:0];

  // lane 0 sits in the least significant position
  always_ff @(posedge avl_clk) begin
    if (wr_en) begin
      mem[wr_row][wr_lane*`DMA_DATA_WIDTH +: `DMA_DATA_WIDTH] <= wr_data;
    end
  end

  // registered wide read, data one cycle after the address
  always_ff @(posedge avl_clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

/* logic/dacfifo_dma_ingress.sv */
`include "dacfifo_defines.svh"

module dacfifo_dma_ingress (
  input  logic                            avl_clk,
  input  logic                            avl_reset,
  input  logic                            xfer_req,
  input  logic                            dma_valid,
  input  logic [`DMA_DATA_WIDTH-1:0]      dma_data,
  input  logic                            dma_last,
  input  logic [`AVL_MEM_ADDR_WIDTH:0]    rd_ptr,
  output logic                            dma_ready,
  output logic                            mem_wr_en,
  output logic [`DMA_ADDR_WIDTH-1:0]      mem_wr_addr,
  output logic [`DMA_DATA_WIDTH-1:0]      mem_wr_data,
  output logic [`AVL_MEM_ADDR_WIDTH:0]    wide_count,
  output logic                            last_seen,
  output dacfifo_pkg::last_beat_t         last_beat
);

  localparam logic [`DMA_ADDR_WIDTH:0] THRESHOLD = `FILL_THRESHOLD;

  // one extra bit so a full buffer differs from an empty one
  logic [`DMA_ADDR_WIDTH:0] wr_ptr;
  logic [`DMA_ADDR_WIDTH:0] fill_level;

  // **************************************************
  // write side of the buffer
  // **************************************************

  assign mem_wr_en   = dma_valid & dma_ready & xfer_req;
  assign mem_wr_addr = wr_ptr[`DMA_ADDR_WIDTH-1:0];
  assign mem_wr_data = dma_data;

  // completed wide words, in the same units as rd_ptr
  assign wide_count = wr_ptr[`DMA_ADDR_WIDTH:`RATIO_BITS];

  // pointers are held cleared outside a transfer
  always_ff @(posedge avl_clk) begin
    if (avl_reset || !xfer_req) begin
      wr_ptr    <= '0;
      last_seen <= 1'b0;
      last_beat <= '0;
    end else if (mem_wr_en) begin
      wr_ptr <= wr_ptr + 1'b1;
      if (dma_last) begin
        last_seen <= 1'b1;
        last_beat <= dacfifo_pkg::last_beat_t'(wr_ptr[`RATIO_BITS-1:0]);
      end
    end
  end

  // **************************************************
  // flow control
  // **************************************************

  // pending narrow words, wide read pointer scaled by the ratio
  assign fill_level = wr_ptr - {rd_ptr, {`RATIO_BITS{1'b0}}};

  // ready lags the fill level by one cycle, threshold leaves room for that
  always_ff @(posedge avl_clk) begin
    if (avl_reset) begin
      dma_ready <= 1'b0;
    end else begin
      dma_ready <= xfer_req && (fill_level < THRESHOLD);
    end
  end

endmodule

/* logic/dacfifo_byteenable_coder.sv */
`include "dacfifo_defines.svh"

module dacfifo_byteenable_coder (
  input  logic                        avl_clk,
  input  dacfifo_pkg::last_beat_t     last_beat,
  input  logic                        final_word,
  output logic [`AVL_BE_WIDTH-1:0]    avl_byteenable
);

  localparam int LANE_BYTES = `DMA_DATA_WIDTH / 8;

  logic [`AVL_BE_WIDTH-1:0] be_next;

  // lanes up to last_beat on the final word, all lanes otherwise
  always_comb begin
    be_next = '0;
    for (int lane = 0; lane < `MEM_RATIO; lane++) begin
      if (!final_word || (lane <= int'(last_beat))) begin
        be_next[lane*LANE_BYTES +: LANE_BYTES] = {LANE_BYTES{1'b1}};
      end
    end
  end

  // final_word settles in FETCH, so this is valid from LOAD on
  always_ff @(posedge avl_clk) begin
    avl_byteenable <= be_next;
  end

endmodule

/* logic/dacfifo_avl_writer.sv */
`include "dacfifo_defines.svh"

module dacfifo_avl_writer (
  input  logic                            avl_clk,
  input  logic                            avl_reset,
  input  logic                            xfer_req,
  input  logic [`AVL_MEM_ADDR_WIDTH:0]    wide_count,
  input  logic                            last_seen,
  input  dacfifo_pkg::last_beat_t         last_beat,
  input  logic [`AVL_DATA_WIDTH-1:0]      mem_rd_data,
  input  logic                            avl_ready,
  input  logic [`AVL_BE_WIDTH-1:0]        last_byteenable,
  output logic [`AVL_MEM_ADDR_WIDTH:0]    rd_ptr,
  output logic                            final_word,
  output logic                            avl_write,
  output logic [`AVL_ADDR_WIDTH-1:0]      avl_address,
  output logic [`AVL_DATA_WIDTH-1:0]      avl_data,
  output logic                            xfer_ack,
  output logic [`AVL_ADDR_WIDTH-1:0]      last_address,
  output logic [`AVL_BE_WIDTH-1:0]        saved_byteenable
);

  localparam logic [`AVL_ADDR_WIDTH-1:0] BASE_ADDR  = `AVL_BASE_ADDRESS;
  localparam logic [`AVL_ADDR_WIDTH-1:0] LIMIT_ADDR = `AVL_ADDRESS_LIMIT;
  localparam dacfifo_pkg::last_beat_t FULL_BEAT = dacfifo_pkg::last_beat_t'(`MEM_RATIO - 1);

  dacfifo_pkg::writer_state_t state;

  logic                         xfer_req_d;
  logic                         xfer_active;
  logic                         write_done;
  logic [`AVL_MEM_ADDR_WIDTH:0] next_ptr;
  logic                         partial_left;
  logic                         word_ready;
  logic                         word_final;

  // **************************************************
  // next word selection
  // **************************************************

  assign write_done = (state == dacfifo_pkg::WRITE) && avl_ready;

  // read pointer as it will be after this cycle
  assign next_ptr = write_done ? rd_ptr + 1'b1 : rd_ptr;

  // a short final word is never counted in wide_count
  assign partial_left = last_seen && (last_beat != FULL_BEAT) && (next_ptr == wide_count);
  assign word_ready   = (next_ptr != wide_count) || partial_left;
  assign word_final   = partial_left ||
                        (last_seen && (last_beat == FULL_BEAT) && (next_ptr + 1'b1 == wide_count));

  // **************************************************
  // write FSM
  // **************************************************

  always_ff @(posedge avl_clk) begin
    if (avl_reset) begin
      state            <= dacfifo_pkg::IDLE;
      xfer_req_d       <= 1'b0;
      xfer_active      <= 1'b0;
      rd_ptr           <= '0;
      final_word       <= 1'b0;
      avl_write        <= 1'b0;
      avl_address      <= BASE_ADDR;
      xfer_ack         <= 1'b0;
      last_address     <= '0;
      saved_byteenable <= '0;
    end else begin
      xfer_req_d <= xfer_req;
      case (state)
        dacfifo_pkg::IDLE: begin
          // new transfer restarts at the base of the window
          if (xfer_req && !xfer_req_d) begin
            xfer_active <= 1'b1;
            avl_address <= BASE_ADDR;
          end else if (xfer_active && word_ready) begin
            state      <= dacfifo_pkg::FETCH;
            final_word <= word_final;
          end
        end
        dacfifo_pkg::FETCH: begin
          state <= dacfifo_pkg::LOAD;
        end
        dacfifo_pkg::LOAD: begin
          state     <= dacfifo_pkg::WRITE;
          avl_write <= 1'b1;
        end
        dacfifo_pkg::WRITE: begin
          if (avl_ready) begin
            avl_write   <= 1'b0;
            rd_ptr      <= next_ptr;
            avl_address <= (avl_address == LIMIT_ADDR) ? BASE_ADDR : avl_address + 1'b1;
            if (final_word) begin
              state            <= dacfifo_pkg::DONE;
              xfer_active      <= 1'b0;
              xfer_ack         <= 1'b1;
              last_address     <= avl_address;
              saved_byteenable <= last_byteenable;
            end else if (word_ready) begin
              state      <= dacfifo_pkg::FETCH;
              final_word <= word_final;
            end else begin
              state <= dacfifo_pkg::IDLE;
            end
          end
        end
        dacfifo_pkg::DONE: begin
          // ingress clears its pointer on the same edge
          if (!xfer_req) begin
            state    <= dacfifo_pkg::IDLE;
            xfer_ack <= 1'b0;
            rd_ptr   <= '0;
          end
        end
        default: begin
          state <= dacfifo_pkg::IDLE;
        end
      endcase
    end
  end

  // wide word arrives from the memory during LOAD
  always_ff @(posedge avl_clk) begin
    if (state == dacfifo_pkg::LOAD) begin
      avl_data <= mem_rd_data;
    end
  end

endmodule

/* logic/dacfifo_wr.sv */
`include "dacfifo_defines.svh"

module dacfifo_wr (
  input  logic                            avl_clk,
  input  logic                            avl_reset,
  input  logic                            xfer_req,
  input  logic                            dma_valid,
  input  logic [`DMA_DATA_WIDTH-1:0]      dma_data,
  input  logic                            dma_last,
  output logic                            dma_ready,
  input  logic                            avl_ready,
  output logic                            avl_write,
  output logic [`AVL_ADDR_WIDTH-1:0]      avl_address,
  output logic [`AVL_DATA_WIDTH-1:0]      avl_data,
  output logic [`AVL_BE_WIDTH-1:0]        avl_byteenable,
  output logic                            xfer_ack,
  output logic [`AVL_ADDR_WIDTH-1:0]      last_address,
  output logic [`AVL_BE_WIDTH-1:0]        saved_byteenable
);

  logic                           mem_wr_en;
  logic [`DMA_ADDR_WIDTH-1:0]     mem_wr_addr;
  logic [`DMA_DATA_WIDTH-1:0]     mem_wr_data;
  logic [`AVL_DATA_WIDTH-1:0]     mem_rd_data;
  logic [`AVL_MEM_ADDR_WIDTH:0]   wide_count;
  logic [`AVL_MEM_ADDR_WIDTH:0]   rd_ptr;
  logic                           last_seen;
  dacfifo_pkg::last_beat_t        last_beat;
  logic                           final_word;

  // **************************************************
  // dma side
  // **************************************************

  dacfifo_dma_ingress u_dma_ingress (
    .avl_clk     (avl_clk),
    .avl_reset   (avl_reset),
    .xfer_req    (xfer_req),
    .dma_valid   (dma_valid),
    .dma_data    (dma_data),
    .dma_last    (dma_last),
    .rd_ptr      (rd_ptr),
    .dma_ready   (dma_ready),
    .mem_wr_en   (mem_wr_en),
    .mem_wr_addr (mem_wr_addr),
    .mem_wr_data (mem_wr_data),
    .wide_count  (wide_count),
    .last_seen   (last_seen),
    .last_beat   (last_beat)
  );

  // narrow in, wide out
  dacfifo_asym_mem u_asym_mem (
    .avl_clk (avl_clk),
    .wr_en   (mem_wr_en),
    .wr_addr (mem_wr_addr),
    .wr_data (mem_wr_data),
    .rd_addr (rd_ptr[`AVL_MEM_ADDR_WIDTH-1:0]),
    .rd_data (mem_rd_data)
  );

  // **************************************************
  // avalon side
  // **************************************************

  dacfifo_avl_writer u_avl_writer (
    .avl_clk          (avl_clk),
    .avl_reset        (avl_reset),
    .xfer_req         (xfer_req),
    .wide_count       (wide_count),
    .last_seen        (last_seen),
    .last_beat        (last_beat),
    .mem_rd_data      (mem_rd_data),
    .avl_ready        (avl_ready),
    .last_byteenable  (avl_byteenable),
    .rd_ptr           (rd_ptr),
    .final_word       (final_word),
    .avl_write        (avl_write),
    .avl_address      (avl_address),
    .avl_data         (avl_data),
    .xfer_ack         (xfer_ack),
    .last_address     (last_address),
    .saved_byteenable (saved_byteenable)
  );

  dacfifo_byteenable_coder u_byteenable_coder (
    .avl_clk        (avl_clk),
    .last_beat      (last_beat),
    .final_word     (final_word),
    .avl_byteenable (avl_byteenable)
  );

endmodule

/* bench/dacfifo_wr_sva.sv */
`include "dacfifo_defines.svh"

module dacfifo_wr_sva (
  input logic                         avl_clk,
  input logic                         avl_reset,
  input logic                         xfer_req,
  input logic                         dma_ready,
  input logic                         avl_ready,
  input logic                         avl_write,
  input logic [`AVL_ADDR_WIDTH-1:0]   avl_address,
  input logic [`AVL_DATA_WIDTH-1:0]   avl_data,
  input logic                         xfer_ack
);

  timeunit 1ns;
  timeprecision 1ps;

  // a pending write holds until the slave takes it
  a_avl_hold: assert property (@(posedge avl_clk) disable iff (avl_reset)
    avl_write && !avl_ready |=> avl_write && $stable(avl_address) && $stable(avl_data))
    else $error("avalon write changed before avl_ready");

  // four-phase handshake, ack stays up until req drops
  a_ack_hold: assert property (@(posedge avl_clk) disable iff (avl_reset)
    xfer_ack && xfer_req |=> xfer_ack)
    else $error("xfer_ack fell while xfer_req was high");

  a_no_write_in_ack: assert property (@(posedge avl_clk) disable iff (avl_reset)
    xfer_ack |-> !avl_write)
    else $error("avl_write high while xfer_ack high");

  a_reset_state: assert property (@(posedge avl_clk)
    avl_reset |=> !dma_ready && !avl_write && !xfer_ack)
    else $error("outputs not idle after reset");

endmodule

bind dacfifo_wr dacfifo_wr_sva u_dacfifo_wr_sva (
  .avl_clk     (avl_clk),
  .avl_reset   (avl_reset),
  .xfer_req    (xfer_req),
  .dma_ready   (dma_ready),
  .avl_ready   (avl_ready),
  .avl_write   (avl_write),
  .avl_address (avl_address),
  .avl_data    (avl_data),
  .xfer_ack    (xfer_ack)
);

/* bench/dacfifo_wr_tb.sv */
`include "dacfifo_defines.svh"

module dacfifo_wr_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_ROWS = 8;
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int BUFFER_WORDS = 2 ** `DMA_ADDR_WIDTH;
  localparam int WINDOW_WORDS = `AVL_ADDRESS_LIMIT - `AVL_BASE_ADDRESS + 1;
  localparam logic [`AVL_BE_WIDTH-1:0] BE_ALL = '1;
  localparam logic [`AVL_ADDR_WIDTH-1:0] BASE_ADDR = `AVL_BASE_ADDRESS;

  // one transfer per row
  typedef struct packed {
    int                       len;
    int                       gap_pct;
    int                       stall_pct;
    int                       long_stall;
    int                       writes;
    int                       last_addr;
    logic [`AVL_BE_WIDTH-1:0] last_be;
  } row_t;

  row_t rows [NUM_ROWS];

  logic                          avl_clk;
  logic                          avl_reset;
  logic                          xfer_req;
  logic                          dma_valid;
  logic [`DMA_DATA_WIDTH-1:0]    dma_data;
  logic                          dma_last;
  logic                          dma_ready;
  logic                          avl_ready;
  logic                          avl_write;
  logic [`AVL_ADDR_WIDTH-1:0]    avl_address;
  logic [`AVL_DATA_WIDTH-1:0]    avl_data;
  logic [`AVL_BE_WIDTH-1:0]      avl_byteenable;
  logic                          xfer_ack;
  logic [`AVL_ADDR_WIDTH-1:0]    last_address;
  logic [`AVL_BE_WIDTH-1:0]      saved_byteenable;

  int seed;
  int avl_seed;
  int stall_pct;
  int stall_left;
  int cycle;
  int writes_done;
  int writes_base;
  int done_cycle;

  // memory model log indexed by write sequence number
  logic [`AVL_ADDR_WIDTH-1:0] wr_addr_log [$];
  logic [`AVL_DATA_WIDTH-1:0] wr_data_log [$];
  logic [`AVL_BE_WIDTH-1:0]   wr_be_log [$];

  dacfifo_wr u_dacfifo_wr (
    .avl_clk          (avl_clk),
    .avl_reset        (avl_reset),
    .xfer_req         (xfer_req),
    .dma_valid        (dma_valid),
    .dma_data         (dma_data),
    .dma_last         (dma_last),
    .dma_ready        (dma_ready),
    .avl_ready        (avl_ready),
    .avl_write        (avl_write),
    .avl_address      (avl_address),
    .avl_data         (avl_data),
    .avl_byteenable   (avl_byteenable),
    .xfer_ack         (xfer_ack),
    .last_address     (last_address),
    .saved_byteenable (saved_byteenable)
  );

  initial begin
    avl_clk = 1'b0;
    forever #20 avl_clk = ~avl_clk;
  end

  // **************************************************
  // avalon memory model
  // **************************************************

  // ready is drawn each cycle and a long stall holds off the first write
  initial begin
    avl_ready = 1'b0;
    forever begin
      @(negedge avl_clk);
      if (stall_left > 0 && avl_write) begin
        avl_ready = 1'b0;
        stall_left = stall_left - 1;
      end else begin
        avl_ready = ({$random(avl_seed)} % 100) >= stall_pct;
      end
    end
  end

  // a write completes on the edge that sees write and ready together
  always @(posedge avl_clk) begin
    cycle <= cycle + 1;
    if (avl_write && avl_ready) begin
      writes_done <= writes_done + 1;
      done_cycle  <= cycle + 1;
      wr_addr_log.push_back(avl_address);
      wr_data_log.push_back(avl_data);
      wr_be_log.push_back(avl_byteenable);
    end
  end

  // **************************************************
  // checks and helpers
  // **************************************************

  task automatic check_equal(input logic [255:0] actual, input logic [255:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("Test failures found");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timed out at %0t ns while waiting for %s", $time, what);
    $display("Test failures found");
    $fatal(1, "wait timed out");
  endtask

  function automatic logic [`DMA_DATA_WIDTH-1:0] make_word(input int t, input int k);
    return {16'(t), 16'hda7a, 32'(k)};
  endfunction

  // dma source whose words move on the edge where valid and ready meet
  task automatic send_words(input int t);
    int   k;
    int   idle;
    int   pending;
    logic fire;
    logic dropped;
    k = 0;
    idle = 0;
    fire = 1'b0;
    dropped = 1'b0;
    while (k < rows[t].len) begin
      @(negedge avl_clk);
      if (fire) begin
        k = k + 1;
        idle = 0;
      end else begin
        idle = idle + 1;
      end
      if (idle > TIMEOUT_CYCLES) timeout_fail("dma_ready");
      pending = k - `MEM_RATIO * (writes_done - writes_base);
      check_equal(256'(pending <= BUFFER_WORDS), 256'(1), "pending dma words within buffer");
      if (!dma_ready && k > 0) dropped = 1'b1;
      if (k < rows[t].len) begin
        dma_valid = ({$random(seed)} % 100) >= rows[t].gap_pct;
        dma_data = make_word(t, k);
        dma_last = (k == rows[t].len - 1);
        fire = dma_valid && dma_ready;
      end else begin
        dma_valid = 1'b0;
        dma_last = 1'b0;
        fire = 1'b0;
      end
    end
    if (rows[t].long_stall > 0) check_equal(256'(dropped), 256'(1), "dma_ready drop on stall");
  endtask

  // packing, address sequence and byte-enables of every logged write
  task automatic check_writes(input int t);
    int                         n;
    int                         k;
    logic [`AVL_ADDR_WIDTH-1:0] exp_addr;
    logic [`AVL_BE_WIDTH-1:0]   exp_be;
    check_equal(256'(wr_addr_log.size()), 256'(rows[t].writes), "write count");
    for (n = 0; n < rows[t].writes; n++) begin
      // write n lands n words into the window, counted modulo its size
      exp_addr = BASE_ADDR + `AVL_ADDR_WIDTH'(n % WINDOW_WORDS);
      exp_be = (n == rows[t].writes - 1) ? rows[t].last_be : BE_ALL;
      check_equal(256'(wr_addr_log[n]), 256'(exp_addr), "write address");
      check_equal(256'(wr_be_log[n]), 256'(exp_be), "write byteenable");
      for (int j = 0; j < `MEM_RATIO; j++) begin
        k = `MEM_RATIO * n + j;
        if (k < rows[t].len) begin
          check_equal(256'(wr_data_log[n][j*`DMA_DATA_WIDTH +: `DMA_DATA_WIDTH]),
                      256'(make_word(t, k)), "packed dma word");
        end
      end
    end
  endtask

  task automatic run_transfer(input int t);
    int idle;
    wr_addr_log.delete();
    wr_data_log.delete();
    wr_be_log.delete();
    stall_pct = rows[t].stall_pct;
    stall_left = rows[t].long_stall;
    writes_base = writes_done;
    @(negedge avl_clk);
    xfer_req = 1'b1;
    send_words(t);
    idle = 0;
    while (!xfer_ack) begin
      @(negedge avl_clk);
      idle = idle + 1;
      if (idle > TIMEOUT_CYCLES) timeout_fail("xfer_ack to rise");
    end
    // ack comes with the edge that completed the final write
    check_equal(256'(writes_done - writes_base), 256'(rows[t].writes), "writes before xfer_ack");
    check_equal(256'(cycle), 256'(done_cycle), "xfer_ack delay after final write");
    check_writes(t);
    check_equal(256'(last_address), 256'(rows[t].last_addr), "last_address");
    check_equal(256'(saved_byteenable), 256'(rows[t].last_be), "saved_byteenable");
    @(negedge avl_clk);
    xfer_req = 1'b0;
    idle = 0;
    while (xfer_ack) begin
      @(negedge avl_clk);
      idle = idle + 1;
      if (idle > TIMEOUT_CYCLES) timeout_fail("xfer_ack to fall");
    end
    check_equal(256'(writes_done - writes_base), 256'(rows[t].writes), "writes after xfer_ack");
  endtask

  // **************************************************
  // main sequence
  // **************************************************

  initial begin
    seed = 22;
    avl_seed = $random(seed);
    avl_reset = 1'b1;
    // request is up during reset, only the reset keeps dma_ready low
    xfer_req = 1'b1;
    dma_valid = 1'b0;
    dma_data = '0;
    dma_last = 1'b0;
    stall_pct = 0;
    stall_left = 0;
    // length, gap %, stall %, long stall, writes, last address, final byte-enable
    rows[0] = '{16, 0, 0, 0, 4, 19, BE_ALL};
    rows[1] = '{13, 20, 20, 0, 4, 19, 32'h0000_00ff};
    rows[2] = '{14, 30, 10, 0, 4, 19, 32'h0000_ffff};
    rows[3] = '{15, 10, 30, 0, 4, 19, 32'h00ff_ffff};
    rows[4] = '{72, 10, 20, 0, 18, 17, BE_ALL};
    rows[5] = '{72, 0, 0, 100, 18, 17, BE_ALL};
    rows[6] = '{5, 25, 25, 0, 2, 17, 32'h0000_00ff};
    rows[7] = '{1, 0, 0, 0, 1, 16, 32'h0000_00ff};
    repeat (3) @(negedge avl_clk);
    avl_reset = 1'b0;
    check_equal(256'(dma_ready), 256'(0), "dma_ready after reset");
    check_equal(256'(avl_write), 256'(0), "avl_write after reset");
    check_equal(256'(xfer_ack), 256'(0), "xfer_ack after reset");
    check_equal(256'(last_address), 256'(0), "last_address after reset");
    check_equal(256'(saved_byteenable), 256'(0), "saved_byteenable after reset");
    xfer_req = 1'b0;
    for (int t = 0; t < NUM_ROWS; t++) begin
      run_transfer(t);
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

/* sources.f */
+incdir+logic
logic/dacfifo_pkg.sv
logic/dacfifo_asym_mem.sv
logic/dacfifo_dma_ingress.sv
logic/dacfifo_byteenable_coder.sv
logic/dacfifo_avl_writer.sv
logic/dacfifo_wr.sv
bench/dacfifo_wr_sva.sv
bench/dacfifo_wr_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := dacfifo_wr_tb
FILELIST   := sources.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# exit status of the simulation is the pass or fail result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
